/* sim.f */
common/ngp_pkg.sv
rtl/ngp_addr_decode.sv
rtl/ngp_bus_front.sv
rtl/ngp_work_ram.sv
rtl/ngp_io_regs.sv
rtl/ngp_bus_resp.sv
rtl/ngp_main_bus.sv
bench/ngp_main_bus_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the main bus testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ngp_main_bus_tb -f sim.f -o ngp_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ngp_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

/* bench/ngp_main_bus_tb.sv */
// main bus testbench
module ngp_main_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;     // cycles allowed per wait
    localparam int K_BUS   = 0;
    localparam int K_FALL  = 1;      // lvbl goes low
    localparam int K_RISE  = 2;      // lvbl goes high
    localparam int K_ACK   = 3;      // snd_ack pulse

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_sel;
    logic [22:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic [14:0] ext_addr;
    logic [15:0] ext_dout;
    logic [15:0] gfx_dout;
    logic [15:0] shd_dout;
    logic [15:0] rom_data;
    logic [1:0]  ext_we;
    logic [1:0]  shd_we;
    logic        gfx_cs;
    logic        rom_cs;
    logic        rom_ok;
    logic        start_button;
    logic        lvbl;
    logic        snd_ack;
    logic [5:0]  joystick;
    logic        vbl_irq;
    logic        snd_nmi;
    logic        snd_rstn;
    logic        snd_en;
    logic [7:0]  snd_dacl;
    logic [7:0]  snd_dacr;

    // external memory models
    logic [15:0] gfx_mem [8192];
    logic [15:0] shd_reg;
    logic [1:0]  gfx_seen_we;    // last strobes seen
    logic [1:0]  shd_seen_we;
    logic [14:0] gfx_seen_addr;
    logic [14:0] shd_seen_addr;
    logic [15:0] gfx_seen_dout;
    logic [15:0] shd_seen_dout;
    logic [31:0] rng;
    int          rom_wait;
    int          rom_delay;      // delay used by the last rom access
    logic        rom_busy;

    // stimulus table
    string       t_name [64];
    int          t_kind [64];
    logic        t_we [64];
    logic [23:0] t_adr [64];
    logic [1:0]  t_sel [64];
    logic [15:0] t_wdata [64];
    logic [15:0] t_rd [64];
    logic        t_chk_rd [64];
    logic        t_chk_out [64];
    logic [19:0] t_out [64];     // en, rstn, nmi, irq, dacl, dacr
    int          t_ext [64];     // 1 gfx, 2 shared ram
    int          n_rows;
    int          err_count;

    ngp_main_bus #(.RAM0_AW(12), .RAM1_AW(11)) u_ngp_main_bus (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // rom answers with its word address scrambled
    function automatic logic [15:0] rom_word(input logic [23:0] badr);
        return {1'b0, badr[15:1]} ^ 16'hA55A;
    endfunction

    // graphics ram only answers while selected
    assign gfx_dout = gfx_cs ? gfx_mem[ext_addr[12:0]] : 16'h0000;
    assign shd_dout = shd_reg;
    assign rom_data = {1'b0, ext_addr} ^ 16'hA55A;

    // memories take their strobes at the falling edge, mid access
    always @(negedge clk) begin
        if (gfx_cs && ext_we != 2'b00) begin
            if (ext_we[0]) gfx_mem[ext_addr[12:0]][7:0] = ext_dout[7:0];
            if (ext_we[1]) gfx_mem[ext_addr[12:0]][15:8] = ext_dout[15:8];
            gfx_seen_we   = ext_we;
            gfx_seen_addr = ext_addr;
            gfx_seen_dout = ext_dout;
        end
        if (shd_we != 2'b00) begin
            if (shd_we[0]) shd_reg[7:0] = ext_dout[7:0];
            if (shd_we[1]) shd_reg[15:8] = ext_dout[15:8];
            shd_seen_we   = shd_we;
            shd_seen_addr = ext_addr;
            shd_seen_dout = ext_dout;
        end
    end

    // rom ready after 0 to 5 cycles
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_busy = 1'b0;
        end else if (!rom_busy) begin
            rng = xorshift(rng);
            rom_wait = int'(rng % 6);
            rom_delay = rom_wait;
            rom_busy = 1'b1;
            rom_ok   = (rom_wait == 0);
        end else if (!rom_ok) begin
            rom_wait = rom_wait - 1;
            rom_ok = (rom_wait <= 0);
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_count++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add_row(input string name, input int kind, input logic we,
                           input logic [23:0] adr, input logic [1:0] sel,
                           input logic [15:0] wdata, input logic [15:0] rd,
                           input logic chk_rd, input logic chk_out,
                           input logic [19:0] out, input int ext);
        t_name[n_rows] = name;
        t_kind[n_rows] = kind;
        t_we[n_rows] = we;
        t_adr[n_rows] = adr;
        t_sel[n_rows] = sel;
        t_wdata[n_rows] = wdata;
        t_rd[n_rows] = rd;
        t_chk_rd[n_rows] = chk_rd;
        t_chk_out[n_rows] = chk_out;
        t_out[n_rows] = out;
        t_ext[n_rows] = ext;
        n_rows++;
    endtask

    // one wishbone cycle, entered and left on a falling edge
    task automatic bus_cycle(input int i);
        int edges;
        edges = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = t_we[i];
        wb_sel = t_sel[i];
        wb_adr = t_adr[i][23:1];
        wb_dat_w = t_wdata[i];
        do begin
            @(negedge clk);
            edges++;
        end while (!wb_ack && edges < TIMEOUT);
        if (!wb_ack) begin
            $display("bus cycle %s got no ack in time", t_name[i]);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
        if (t_adr[i] >= 24'hFF0000) begin
            check_val({t_name[i], " ack edges"}, 3 + rom_delay, edges);
        end else begin
            check_val({t_name[i], " ack edges"}, 3, edges);
        end
        if (t_chk_rd[i]) check_val(t_name[i], t_rd[i], wb_dat_r);
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        @(negedge clk);
        check_val({t_name[i], " ack width"}, 0, wb_ack);
    endtask

    task automatic run_row(input int i);
        int n;
        gfx_seen_we = 2'b00;
        shd_seen_we = 2'b00;
        case (t_kind[i])
            K_FALL: lvbl = 1'b0;
            K_RISE: lvbl = 1'b1;
            K_ACK:  snd_ack = 1'b1;
            default: bus_cycle(i);
        endcase
        if (t_kind[i] != K_BUS) begin
            @(negedge clk);
            snd_ack = 1'b0;
            for (n = 0; n < 2; n++) @(negedge clk);  // edge detect settles
        end
        if (t_ext[i] == 1) begin
            check_val({t_name[i], " ext_we"}, t_sel[i], gfx_seen_we);
            check_val({t_name[i], " ext_addr"}, t_adr[i][15:1], gfx_seen_addr);
            check_val({t_name[i], " ext_dout"}, t_wdata[i], gfx_seen_dout);
        end else if (t_ext[i] == 2) begin
            check_val({t_name[i], " shd_we"}, t_sel[i], shd_seen_we);
            check_val({t_name[i], " shd addr"}, t_adr[i][15:1], shd_seen_addr);
            check_val({t_name[i], " shd dout"}, t_wdata[i], shd_seen_dout);
        end
        if (t_chk_out[i]) begin
            check_val({t_name[i], " io outputs"}, t_out[i],
                      {snd_en, snd_rstn, snd_nmi, vbl_irq, snd_dacl, snd_dacr});
        end
    endtask

    initial begin
        rst = 1'b1;
        {wb_cyc, wb_stb, wb_we, wb_sel, wb_adr, wb_dat_w} = '0;
        rom_ok = 1'b0;
        rom_busy = 1'b0;
        rom_delay = 0;
        rom_wait = 0;
        rng = 32'd17248;
        shd_reg = 16'h0;
        start_button = 1'b0;       // pressed, active low
        joystick = 6'b101010;
        lvbl = 1'b1;
        snd_ack = 1'b0;
        n_rows = 0;
        err_count = 0;
        for (int a = 0; a < 8192; a++) gfx_mem[a] = 16'(a * 16'h9E37) ^ 16'h5A5A;

        // work rams, lane merge, independence at the same word index
        add_row("ram0 full", K_BUS, 1, 24'h0040A2, 2'b11, 16'h1234, 0, 0, 0, 0, 0);
        add_row("ram0 lo", K_BUS, 1, 24'h0040A2, 2'b01, 16'h00AB, 0, 0, 0, 0, 0);
        add_row("ram0 rd1", K_BUS, 0, 24'h0040A2, 2'b11, 0, 16'h12AB, 1, 0, 0, 0);
        add_row("ram0 hi", K_BUS, 1, 24'h0040A2, 2'b10, 16'hCD00, 0, 0, 0, 0, 0);
        add_row("ram0 rd2", K_BUS, 0, 24'h0040A2, 2'b11, 0, 16'hCDAB, 1, 0, 0, 0);
        add_row("ram1 full", K_BUS, 1, 24'h0060A2, 2'b11, 16'h5678, 0, 0, 0, 0, 0);
        add_row("ram1 rd", K_BUS, 0, 24'h0060A2, 2'b11, 0, 16'h5678, 1, 0, 0, 0);
        add_row("ram0 kept", K_BUS, 0, 24'h0040A2, 2'b11, 0, 16'hCDAB, 1, 0, 0, 0);
        // graphics and shared ram
        add_row("gfx full", K_BUS, 1, 24'h008020, 2'b11, 16'hBEEF, 0, 0, 0, 0, 1);
        add_row("gfx hi", K_BUS, 1, 24'h008020, 2'b10, 16'h1200, 0, 0, 0, 0, 1);
        add_row("gfx rd", K_BUS, 0, 24'h008020, 2'b11, 0, 16'h12EF, 1, 0, 0, 0);
        add_row("shd full", K_BUS, 1, 24'h007000, 2'b11, 16'h4321, 0, 0, 0, 0, 2);
        add_row("shd lo", K_BUS, 1, 24'h007000, 2'b01, 16'h0099, 0, 0, 0, 0, 2);
        add_row("shd rd", K_BUS, 0, 24'h007000, 2'b11, 0, 16'h4399, 1, 0, 0, 0);
        // rom with random latency
        add_row("rom a", K_BUS, 0, 24'hFF0000, 2'b11, 0, rom_word(24'hFF0000), 1, 0, 0, 0);
        add_row("rom b", K_BUS, 0, 24'hFF1234, 2'b11, 0, rom_word(24'hFF1234), 1, 0, 0, 0);
        add_row("rom c", K_BUS, 0, 24'hFF8ACE, 2'b11, 0, rom_word(24'hFF8ACE), 1, 0, 0, 0);
        add_row("rom d", K_BUS, 0, 24'hFFFFFE, 2'b11, 0, rom_word(24'hFFFFFE), 1, 0, 0, 0);
        add_row("rom e", K_BUS, 0, 24'hFF0402, 2'b11, 0, rom_word(24'hFF0402), 1, 0, 0, 0);
        // i/o block
        add_row("joy rd", K_BUS, 0, 24'h0000B0, 2'b11, 0, 16'h0355, 1, 0, 0, 0);
        add_row("snd ctl", K_BUS, 1, 24'h0000B8, 2'b11, 16'h0001, 0, 0, 1, 20'h80000, 0);
        add_row("dac", K_BUS, 1, 24'h0000A2, 2'b11, 16'h7F80, 0, 0, 1, 20'h87F80, 0);
        add_row("nmi set", K_BUS, 1, 24'h0000BA, 2'b01, 16'h0001, 0, 0, 1, 20'hA7F80, 0);
        add_row("nmi ack", K_ACK, 0, 0, 0, 0, 0, 0, 1, 20'h87F80, 0);
        add_row("nmi set2", K_BUS, 1, 24'h0000BA, 2'b01, 16'h0001, 0, 0, 1, 20'hA7F80, 0);
        add_row("ctl hi", K_BUS, 1, 24'h0000B8, 2'b10, 16'h0100, 0, 0, 1, 20'hC7F80, 0);
        // vertical blank latch
        add_row("vbl fall", K_FALL, 0, 0, 0, 0, 0, 0, 1, 20'hD7F80, 0);
        add_row("irq rd1", K_BUS, 0, 24'h0000BC, 2'b11, 0, 16'h0001, 1, 0, 0, 0);
        add_row("irq clr", K_BUS, 1, 24'h0000BC, 2'b01, 16'h0000, 0, 0, 1, 20'hC7F80, 0);
        add_row("vbl rise", K_RISE, 0, 0, 0, 0, 0, 0, 1, 20'hC7F80, 0);
        add_row("irq rd0", K_BUS, 0, 24'h0000BC, 2'b11, 0, 16'h0000, 1, 0, 0, 0);
        // unmapped space, low bits alias the dac offset and both ram words
        add_row("none wr", K_BUS, 1, 24'h0020A2, 2'b11, 16'hFFFF, 0, 0, 1, 20'hC7F80, 0);
        add_row("ram0 after", K_BUS, 0, 24'h0040A2, 2'b11, 0, 16'hCDAB, 1, 0, 0, 0);
        add_row("ram1 after", K_BUS, 0, 24'h0060A2, 2'b11, 0, 16'h5678, 1, 0, 0, 0);
        add_row("none rd", K_BUS, 0, 24'h0020A2, 2'b11, 0, 16'h0000, 1, 0, 0, 0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("reset outputs", 0,
                  {wb_ack, gfx_cs, rom_cs, ext_we, shd_we,
                   snd_en, snd_rstn, snd_nmi, vbl_irq, snd_dacl, snd_dacr});
        for (int i = 0; i < n_rows; i++) run_row(i);

        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/ngp_main_bus.sv */
// main cpu bus subsystem
module ngp_main_bus #(
    parameter int RAM0_AW = 12, // 8 kB
    parameter int RAM1_AW = 11  // 4 kB
) (
    input  logic                clk,
    input  logic                rst,
    // wishbone slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  ngp_pkg::sel_t       wb_sel,
    input  ngp_pkg::word_addr_t wb_adr,
    input  ngp_pkg::data_t      wb_dat_w,
    output ngp_pkg::data_t      wb_dat_r,
    output logic                wb_ack,
    // external memories
    output ngp_pkg::ext_addr_t  ext_addr,
    output ngp_pkg::data_t      ext_dout,
    output ngp_pkg::sel_t       ext_we,
    output ngp_pkg::sel_t       shd_we,
    output logic                gfx_cs,
    input  ngp_pkg::data_t      gfx_dout,
    input  ngp_pkg::data_t      shd_dout,
    output logic                rom_cs,
    input  ngp_pkg::data_t      rom_data,
    input  logic                rom_ok,
    // i/o pins
    input  logic                start_button,
    input  logic [5:0]          joystick,
    input  logic                lvbl,
    output logic                vbl_irq,
    input  logic                snd_ack,
    output logic                snd_nmi,
    output logic                snd_rstn,
    output logic                snd_en,
    output logic [7:0]          snd_dacl,
    output logic [7:0]          snd_dacr
);

    ngp_pkg::word_addr_t req_adr;
    ngp_pkg::data_t      req_dat;
    ngp_pkg::region_t    region;
    ngp_pkg::sel_t       ram0_we;
    ngp_pkg::sel_t       ram1_we;
    ngp_pkg::sel_t       io_we;
    ngp_pkg::data_t      ram0_q;
    ngp_pkg::data_t      ram1_q;
    ngp_pkg::data_t      io_rdata;
    logic                done;

    assign ext_addr = req_adr[14:0]; // byte bits 15:1
    assign ext_dout = req_dat;

    ngp_bus_front u_front (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_sel   ( wb_sel   ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .rom_ok   ( rom_ok   ),
        .req_adr  ( req_adr  ),
        .req_dat  ( req_dat  ),
        .region   ( region   ),
        .ram0_we  ( ram0_we  ),
        .ram1_we  ( ram1_we  ),
        .io_we    ( io_we    ),
        .ext_we   ( ext_we   ),
        .shd_we   ( shd_we   ),
        .gfx_cs   ( gfx_cs   ),
        .rom_cs   ( rom_cs   ),
        .done     ( done     )
    );

    ngp_work_ram #(.AW(RAM0_AW)) u_ram0 (
        .clk   ( clk                    ),
        .addr  ( req_adr[RAM0_AW-1:0]   ), // byte bits 12:1
        .wdata ( req_dat                ),
        .we    ( ram0_we                ),
        .q     ( ram0_q                 )
    );

    ngp_work_ram #(.AW(RAM1_AW)) u_ram1 (
        .clk   ( clk                    ),
        .addr  ( req_adr[RAM1_AW-1:0]   ), // byte bits 11:1
        .wdata ( req_dat                ),
        .we    ( ram1_we                ),
        .q     ( ram1_q                 )
    );

    ngp_io_regs u_io (
        .clk          ( clk                    ),
        .rst          ( rst                    ),
        .offset       ( {req_adr[6:0], 1'b0}   ), // low byte of the address
        .wdata        ( req_dat                ),
        .we           ( io_we                  ),
        .rdata        ( io_rdata               ),
        .start_button ( start_button           ),
        .joystick     ( joystick               ),
        .lvbl         ( lvbl                   ),
        .vbl_irq      ( vbl_irq                ),
        .snd_ack      ( snd_ack                ),
        .snd_nmi      ( snd_nmi                ),
        .snd_rstn     ( snd_rstn               ),
        .snd_en       ( snd_en                 ),
        .snd_dacl     ( snd_dacl               ),
        .snd_dacr     ( snd_dacr               )
    );

    ngp_bus_resp u_resp (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .done     ( done     ),
        .region   ( region   ),
        .ram0_q   ( ram0_q   ),
        .ram1_q   ( ram1_q   ),
        .io_rdata ( io_rdata ),
        .gfx_dout ( gfx_dout ),
        .shd_dout ( shd_dout ),
        .rom_data ( rom_data ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   )
    );

endmodule

/* rtl/ngp_bus_resp.sv */
// read data mux and ack
module ngp_bus_resp (
    input  logic             clk,
    input  logic             rst,
    input  logic             done,
    input  ngp_pkg::region_t region,
    input  ngp_pkg::data_t   ram0_q,
    input  ngp_pkg::data_t   ram1_q,
    input  ngp_pkg::data_t   io_rdata,
    input  ngp_pkg::data_t   gfx_dout,
    input  ngp_pkg::data_t   shd_dout,
    input  ngp_pkg::data_t   rom_data,
    output ngp_pkg::data_t   wb_dat_r,
    output logic             wb_ack
);

    ngp_pkg::data_t rd_sel;

    // source picked by the captured region
    always_comb begin
        case (region)
            ngp_pkg::RGN_IO:   rd_sel = io_rdata;
            ngp_pkg::RGN_RAM0: rd_sel = ram0_q;
            ngp_pkg::RGN_RAM1: rd_sel = ram1_q;
            ngp_pkg::RGN_SHD:  rd_sel = shd_dout;
            ngp_pkg::RGN_GFX:  rd_sel = gfx_dout;
            ngp_pkg::RGN_ROM:  rd_sel = rom_data;
            default:           rd_sel = 16'd0; // unmapped reads as zero
        endcase
    end

    // done lasts one cycle, so does ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) wb_dat_r <= rd_sel; // held until the next cycle
    end

endmodule

/* rtl/ngp_io_regs.sv */
// main cpu i/o registers
module ngp_io_regs (
    input  logic             clk,
    input  logic             rst,
    input  ngp_pkg::io_ofs_t offset,
    input  ngp_pkg::data_t   wdata,
    input  ngp_pkg::sel_t    we,
    output ngp_pkg::data_t   rdata,
    input  logic             start_button, // active low at the pin
    input  logic [5:0]       joystick,     // active low at the pin
    input  logic             lvbl,
    output logic             vbl_irq,
    input  logic             snd_ack,
    output logic             snd_nmi,
    output logic             snd_rstn,
    output logic             snd_en,
    output logic [7:0]       snd_dacl,
    output logic [7:0]       snd_dacr
);

    logic lvbl_l;     // lvbl one cycle ago
    logic vbl_fall;
    logic wr_ctl_lo;
    logic wr_ctl_hi;
    logic wr_nmi;
    logic wr_dac_lo;
    logic wr_dac_hi;
    logic wr_irq;

    assign vbl_fall = lvbl_l && !lvbl; // blanking starts

    // register hits per lane
    assign wr_ctl_lo = we[0] && (offset == ngp_pkg::IO_SND_CTL);
    assign wr_ctl_hi = we[1] && (offset == ngp_pkg::IO_SND_CTL);
    assign wr_nmi    = we[0] && (offset == ngp_pkg::IO_SND_NMI);
    assign wr_dac_lo = we[0] && (offset == ngp_pkg::IO_DAC);
    assign wr_dac_hi = we[1] && (offset == ngp_pkg::IO_DAC);
    assign wr_irq    = we[0] && (offset == ngp_pkg::IO_IRQ); // any value clears

    // sound cpu control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_en   <= 1'b0;
            snd_rstn <= 1'b0;  // sound cpu held in reset
            snd_nmi  <= 1'b0;
        end else begin
            if (snd_ack) snd_nmi <= 1'b0; // acknowledged by the z80 side
            if (wr_ctl_lo) snd_en <= wdata[0];
            if (wr_ctl_hi) begin
                snd_rstn <= wdata[8];
                snd_nmi  <= 1'b0;
            end
            if (wr_nmi) snd_nmi <= 1'b1; // set beats ack in the same cycle
        end
    end

    // dac bytes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_dacl <= 8'd0;
            snd_dacr <= 8'd0;
        end else begin
            if (wr_dac_lo) snd_dacr <= wdata[ 7:0];
            if (wr_dac_hi) snd_dacl <= wdata[15:8];
        end
    end

    // vblank interrupt latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l  <= 1'b0; // no false edge out of reset
            vbl_irq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (wr_irq)   vbl_irq <= 1'b0;
            if (vbl_fall) vbl_irq <= 1'b1; // edge wins over the clear
        end
    end

    // read port
    always_comb begin
        case (offset)
            ngp_pkg::IO_JOY: rdata = {ngp_pkg::JOY_ID, 1'b0, ~start_button, ~joystick};
            ngp_pkg::IO_IRQ: rdata = {15'd0, vbl_irq};
            default:         rdata = 16'd0; // write-only or unused
        endcase
    end

endmodule

/* rtl/ngp_work_ram.sv */
// work ram, byte lane writes
module ngp_work_ram #(
    parameter int AW = 12  // word address width
) (
    input  logic           clk,
    input  logic [AW-1:0]  addr,
    input  ngp_pkg::data_t wdata,
    input  ngp_pkg::sel_t  we,
    output ngp_pkg::data_t q
);

    ngp_pkg::data_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (we[0]) mem[addr][ 7:0] <= wdata[ 7:0]; // even byte
        if (we[1]) mem[addr][15:8] <= wdata[15:8]; // odd byte
        q <= mem[addr]; // old word on a write cycle
    end

endmodule

/* rtl/ngp_bus_front.sv */
// wishbone slave front end
module ngp_bus_front (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  ngp_pkg::sel_t       wb_sel,
    input  ngp_pkg::word_addr_t wb_adr,
    input  ngp_pkg::data_t      wb_dat_w,
    input  logic                rom_ok,
    output ngp_pkg::word_addr_t req_adr,
    output ngp_pkg::data_t      req_dat,
    output ngp_pkg::region_t    region,
    output ngp_pkg::sel_t       ram0_we,
    output ngp_pkg::sel_t       ram1_we,
    output ngp_pkg::sel_t       io_we,
    output ngp_pkg::sel_t       ext_we,
    output ngp_pkg::sel_t       shd_we,
    output logic                gfx_cs,
    output logic                rom_cs,
    output logic                done
);

    ngp_pkg::bus_state_t state;
    ngp_pkg::region_t    dec_region;
    ngp_pkg::sel_t       req_sel;
    ngp_pkg::sel_t       wr_lanes;
    logic                req_we;
    logic                start;
    logic                active;       // access or latch phase

    ngp_addr_decode u_decode (
        .adr    ( wb_adr     ),
        .region ( dec_region )
    );

    assign start  = wb_cyc && wb_stb && (state == ngp_pkg::ST_IDLE);
    assign active = (state == ngp_pkg::ST_ACCESS) || (state == ngp_pkg::ST_LATCH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ngp_pkg::ST_IDLE;
            region <= ngp_pkg::RGN_NONE;
            req_we <= 1'b0;
        end else begin
            case (state)
                ngp_pkg::ST_IDLE: if (start) begin
                    state  <= ngp_pkg::ST_ACCESS; // E0, request sampled
                    region <= dec_region;
                    req_we <= wb_we;
                end
                ngp_pkg::ST_ACCESS: begin
                    // rom holds here until its data is ready
                    if (region != ngp_pkg::RGN_ROM || rom_ok) state <= ngp_pkg::ST_LATCH;
                end
                ngp_pkg::ST_LATCH: state <= ngp_pkg::ST_DONE; // resp takes data now
                ngp_pkg::ST_DONE:  if (!wb_stb) state <= ngp_pkg::ST_IDLE; // no double ack
                default: state <= ngp_pkg::ST_IDLE;
            endcase
        end
    end

    // request payload, loaded only when a cycle starts
    always_ff @(posedge clk) begin
        if (start) begin
            req_adr <= wb_adr;
            req_dat <= wb_dat_w;
            req_sel <= wb_sel;
        end
    end

    // lanes live only during access, reads never strobe
    assign wr_lanes = (state == ngp_pkg::ST_ACCESS && req_we) ? req_sel : 2'b00;

    // each target sees only its own writes
    assign ram0_we = (region == ngp_pkg::RGN_RAM0) ? wr_lanes : 2'b00;
    assign ram1_we = (region == ngp_pkg::RGN_RAM1) ? wr_lanes : 2'b00;
    assign io_we   = (region == ngp_pkg::RGN_IO)   ? wr_lanes : 2'b00;
    assign ext_we  = (region == ngp_pkg::RGN_GFX)  ? wr_lanes : 2'b00;
    assign shd_we  = (region == ngp_pkg::RGN_SHD)  ? wr_lanes : 2'b00;

    assign gfx_cs = active && (region == ngp_pkg::RGN_GFX);
    assign rom_cs = active && (region == ngp_pkg::RGN_ROM);
    assign done   = (state == ngp_pkg::ST_LATCH); // one cycle strobe to resp

endmodule

/* rtl/ngp_addr_decode.sv */
// address region decoder
module ngp_addr_decode (
    input  ngp_pkg::word_addr_t adr,
    output ngp_pkg::region_t    region
);

    ngp_pkg::byte_addr_t ba;

    // half-open range test on the full byte address
    function automatic logic in_range(
        input ngp_pkg::byte_addr_t a,
        input ngp_pkg::byte_addr_t lo,
        input ngp_pkg::byte_addr_t hi
    );
        in_range = (a >= lo) && (a < hi);
    endfunction

    assign ba = {adr, 1'b0}; // word address back to bytes

    // first match wins
    always_comb begin
        if (in_range(ba, ngp_pkg::IO_LO, ngp_pkg::IO_HI)) begin
            region = ngp_pkg::RGN_IO;
        end else if (in_range(ba, ngp_pkg::RAM0_LO, ngp_pkg::RAM0_HI)) begin
            region = ngp_pkg::RGN_RAM0;
        end else if (in_range(ba, ngp_pkg::RAM1_LO, ngp_pkg::RAM1_HI)) begin
            region = ngp_pkg::RGN_RAM1;
        end else if (in_range(ba, ngp_pkg::SHD_LO, ngp_pkg::SHD_HI)) begin
            region = ngp_pkg::RGN_SHD;
        end else if (in_range(ba, ngp_pkg::GFX_LO, ngp_pkg::GFX_HI)) begin
            region = ngp_pkg::RGN_GFX;
        end else if (ba >= ngp_pkg::ROM_BASE) begin
            region = ngp_pkg::RGN_ROM;  // open ended, top of space
        end else begin
            region = ngp_pkg::RGN_NONE; // unmapped, acked anyway
        end
    end

endmodule

/* common/ngp_pkg.sv */
// main bus shared definitions
package ngp_pkg;

    // bus widths
    typedef logic [22:0] word_addr_t; // byte address bits 23:1
    typedef logic [15:0] data_t;
    typedef logic [ 1:0] sel_t;       // bit 0 = low byte, even address
    typedef logic [14:0] ext_addr_t;  // byte address bits 15:1
    typedef logic [ 7:0] io_ofs_t;    // byte offset inside the i/o window
    typedef logic [23:0] byte_addr_t;

    // decoded target of a bus cycle
    typedef enum logic [2:0] {
        RGN_NONE,
        RGN_IO,
        RGN_RAM0,
        RGN_RAM1,
        RGN_SHD,
        RGN_GFX,
        RGN_ROM
    } region_t;

    // front end sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_LATCH,
        ST_DONE
    } bus_state_t;

    // memory map, lower bound inclusive, upper exclusive
    localparam byte_addr_t IO_LO    = 24'h00_0080;
    localparam byte_addr_t IO_HI    = 24'h00_00C0;
    localparam byte_addr_t RAM0_LO  = 24'h00_4000; // 8 kB work ram
    localparam byte_addr_t RAM0_HI  = 24'h00_6000;
    localparam byte_addr_t RAM1_LO  = 24'h00_6000; // 4 kB work ram
    localparam byte_addr_t RAM1_HI  = 24'h00_7000;
    localparam byte_addr_t SHD_LO   = 24'h00_7000; // shared with sound cpu
    localparam byte_addr_t SHD_HI   = 24'h00_8000;
    localparam byte_addr_t GFX_LO   = 24'h00_8000; // 16 kB graphics ram
    localparam byte_addr_t GFX_HI   = 24'h00_C000;
    localparam byte_addr_t ROM_BASE = 24'hFF_0000; // firmware, up to the top

    // i/o register offsets
    localparam io_ofs_t IO_DAC     = 8'hA2; // lo = right dac, hi = left dac
    localparam io_ofs_t IO_JOY     = 8'hB0;
    localparam io_ofs_t IO_SND_CTL = 8'hB8; // bit 0 enable, bit 8 reset release
    localparam io_ofs_t IO_SND_NMI = 8'hBA;
    localparam io_ofs_t IO_IRQ     = 8'hBC; // vblank latch in bit 0

    // upper byte of the joystick read
    localparam logic [7:0] JOY_ID = 8'h03;

endpackage
